// File: src/adapter_pkg.sv
// Die-to-die link adapter package
// Lane and flit widths, stream and protocol encodings, sequencer states
package adapter_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Number of PHY lanes
  localparam int aib_lanes = 4;

  // One flit per transfer
  localparam int flit_width = 64;

  // One bit per lane, for transfer enables and adapter resets
  typedef logic [aib_lanes-1:0] lane_vec_t;

  typedef logic [flit_width-1:0] flit_t;

  ////////////////////
  // Encodings
  ////////////////////

  // One-hot stream IDs on the link layer side
  typedef enum logic [2:0] {
    stream_mem_cache = 3'b001,
    stream_io        = 3'b010,
    stream_arb_mux   = 3'b100
  } stream_id_e;

  // Protocol IDs on the PHY side, code 3 is unused
  typedef enum logic [1:0] {
    protid_cache   = 2'd0,
    protid_io      = 2'd1,
    protid_arb_mux = 2'd2
  } protid_e;

  // Bring-up sequencer states
  typedef enum logic [2:0] {
    ctl_idle          = 3'd0,
    ctl_phy_init      = 3'd1,
    ctl_cfg           = 3'd2,
    ctl_calib         = 3'd3,
    ctl_wait_ca_align = 3'd4,
    ctl_link_up       = 3'd5
  } ctl_state_e;

endpackage

// File: src/link_bringup_fsm.sv
// Link bring-up sequencer
// Raises MAC ready, releases lane resets, marks TX/RX online and waits for alignment
`timescale 1ns/1ps

module link_bringup_fsm (
  input  logic                   com_clk,
  input  logic                   rst_n,
  input  logic                   i_conf_done,
  input  adapter_pkg::lane_vec_t ms_tx_transfer_en,
  input  adapter_pkg::lane_vec_t ms_rx_transfer_en,
  input  adapter_pkg::lane_vec_t sl_tx_transfer_en,
  input  adapter_pkg::lane_vec_t sl_rx_transfer_en,
  input  logic                   align_done,
  output logic                   ns_mac_rdy,
  output adapter_pkg::lane_vec_t ns_adapter_rstn,
  output logic                   tx_online,
  output logic                   rx_online,
  output logic                   link_up
);

  import adapter_pkg::*;

  ctl_state_e ctl_state;
  ctl_state_e ctl_state_nxt;

  logic      mac_rdy_nxt;
  lane_vec_t adapter_rstn_nxt;
  logic      online_nxt;
  logic      all_xfer_en;

  // Every lane enabled in both directions on both sides
  assign all_xfer_en = (&ms_tx_transfer_en) & (&ms_rx_transfer_en) &
                       (&sl_tx_transfer_en) & (&sl_rx_transfer_en);

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    ctl_state_nxt    = ctl_state;
    mac_rdy_nxt      = ns_mac_rdy;
    adapter_rstn_nxt = ns_adapter_rstn;
    online_nxt       = tx_online;

    case (ctl_state)
      ctl_idle: begin
        ctl_state_nxt = ctl_phy_init;
      end
      ctl_phy_init: begin
        // Hold until the PHY config is loaded
        if (i_conf_done) begin
          mac_rdy_nxt   = 1'b1;
          ctl_state_nxt = ctl_cfg;
        end
      end
      ctl_cfg: begin
        // Release all lane adapters together
        adapter_rstn_nxt = '1;
        ctl_state_nxt    = ctl_calib;
      end
      ctl_calib: begin
        if (all_xfer_en) begin
          online_nxt    = 1'b1;
          ctl_state_nxt = ctl_wait_ca_align;
        end
      end
      ctl_wait_ca_align: begin
        if (align_done) begin
          ctl_state_nxt = ctl_link_up;
        end
      end
      ctl_link_up: begin
        // Only reset leaves link up
        ctl_state_nxt = ctl_link_up;
      end
      default: begin
        ctl_state_nxt = ctl_idle;
      end
    endcase
  end

  ////////////////////
  // State and outputs
  ////////////////////

  always_ff @(posedge com_clk or negedge rst_n) begin
    if (!rst_n) begin
      ctl_state       <= ctl_idle;
      ns_mac_rdy      <= 1'b0;
      ns_adapter_rstn <= '0;
      tx_online       <= 1'b0;
      rx_online       <= 1'b0;
      link_up         <= 1'b0;
    end else begin
      ctl_state       <= ctl_state_nxt;
      ns_mac_rdy      <= mac_rdy_nxt;
      ns_adapter_rstn <= adapter_rstn_nxt;
      tx_online       <= online_nxt;
      rx_online       <= online_nxt;
      // Registered with the state so it tracks ctl_link_up exactly
      link_up         <= (ctl_state_nxt == ctl_link_up);
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  // Lanes come out of reset only once the MAC is ready
  a_rstn_after_mac_rdy : assert property (
    @(posedge com_clk) disable iff (!rst_n)
    (|ns_adapter_rstn) |-> ns_mac_rdy
  );

  a_link_up_online : assert property (
    @(posedge com_clk) disable iff (!rst_n)
    link_up |-> (tx_online && rx_online)
  );

  // Bring-up outputs never drop without reset, so link up is terminal
  a_outputs_sticky : assert property (
    @(posedge com_clk) disable iff (!rst_n)
    !$fell(ns_mac_rdy) && !$fell(tx_online) && !$fell(rx_online) && !$fell(link_up)
  );

endmodule

// File: src/dstrm_path.sv
// Downstream path, link layer to PHY
// Registers the flit and maps the one-hot stream ID to a protocol ID
`timescale 1ns/1ps

module dstrm_path (
  input  logic                    com_clk,
  input  logic                    rst_n,
  input  logic                    link_up,
  input  logic                    lp_irdy,
  input  adapter_pkg::flit_t      lp_data,
  input  adapter_pkg::stream_id_e lp_stream,
  output adapter_pkg::flit_t      dstrm_data,
  output adapter_pkg::protid_e    dstrm_protid,
  output logic                    dstrm_valid
);

  import adapter_pkg::*;

  protid_e protid;

  // Stream to protocol, unknown codes fall back to cache
  always_comb begin
    case (lp_stream)
      stream_mem_cache: protid = protid_cache;
      stream_io:        protid = protid_io;
      stream_arb_mux:   protid = protid_arb_mux;
      default:          protid = protid_cache;
    endcase
  end

  ////////////////////
  // Output register
  ////////////////////

  always_ff @(posedge com_clk or negedge rst_n) begin
    if (!rst_n) begin
      dstrm_data   <= '0;
      dstrm_protid <= protid_cache;
      dstrm_valid  <= 1'b0;
    end else begin
      dstrm_data   <= lp_data;
      dstrm_protid <= protid;
      // Transfers ahead of link up are dropped
      dstrm_valid  <= lp_irdy & link_up;
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  // Link up from the sequencer is still high while a flit goes out
  a_valid_needs_link : assert property (
    @(posedge com_clk) disable iff (!rst_n)
    dstrm_valid |-> link_up
  );

endmodule

// File: src/ustrm_path.sv
// Upstream path, PHY to link layer
// Registers the flit and maps the protocol ID back to a one-hot stream ID
`timescale 1ns/1ps

module ustrm_path (
  input  logic                    com_clk,
  input  logic                    rst_n,
  input  logic                    ustrm_valid,
  input  adapter_pkg::flit_t      ustrm_data,
  input  adapter_pkg::protid_e    ustrm_protid,
  output adapter_pkg::flit_t      pl_data,
  output logic                    pl_valid,
  output adapter_pkg::stream_id_e pl_stream
);

  import adapter_pkg::*;

  stream_id_e stream;

  // Protocol to stream, code 3 lands on mem/cache
  always_comb begin
    case (ustrm_protid)
      protid_cache:   stream = stream_mem_cache;
      protid_io:      stream = stream_io;
      protid_arb_mux: stream = stream_arb_mux;
      default:        stream = stream_mem_cache;
    endcase
  end

  always_ff @(posedge com_clk or negedge rst_n) begin
    if (!rst_n) begin
      pl_data   <= '0;
      pl_valid  <= 1'b0;
      // All zero until the first edge out of reset
      pl_stream <= stream_id_e'(3'b000);
    end else begin
      pl_data   <= ustrm_data;
      pl_valid  <= ustrm_valid;
      pl_stream <= stream;
    end
  end

  // One-hot from the first registered value on
  a_stream_onehot : assert property (
    @(posedge com_clk) disable iff (!rst_n)
    $past(rst_n) |-> $onehot(pl_stream)
  );

endmodule

// File: src/lpif_adapter_top.sv
// Die-to-die link adapter control, top level
// Bring-up sequencer plus registered downstream and upstream paths
`timescale 1ns/1ps

module lpif_adapter_top (
  input  logic                               com_clk,
  input  logic                               rst_n,

  // PHY bring-up
  input  logic                               i_conf_done,
  input  logic [adapter_pkg::aib_lanes-1:0]  ms_tx_transfer_en,
  input  logic [adapter_pkg::aib_lanes-1:0]  ms_rx_transfer_en,
  input  logic [adapter_pkg::aib_lanes-1:0]  sl_tx_transfer_en,
  input  logic [adapter_pkg::aib_lanes-1:0]  sl_rx_transfer_en,
  input  logic                               align_done,
  output logic                               ns_mac_rdy,
  output logic [adapter_pkg::aib_lanes-1:0]  ns_adapter_rstn,
  output logic                               tx_online,
  output logic                               rx_online,
  output logic                               link_up,
  output logic                               pl_trdy,

  // Link layer to PHY
  input  logic                               lp_irdy,
  input  logic [adapter_pkg::flit_width-1:0] lp_data,
  input  logic [2:0]                         lp_stream,
  output logic [adapter_pkg::flit_width-1:0] dstrm_data,
  output logic [1:0]                         dstrm_protid,
  output logic                               dstrm_valid,

  // PHY to link layer
  input  logic                               ustrm_valid,
  input  logic [adapter_pkg::flit_width-1:0] ustrm_data,
  input  logic [1:0]                         ustrm_protid,
  output logic [adapter_pkg::flit_width-1:0] pl_data,
  output logic                               pl_valid,
  output logic [2:0]                         pl_stream
);

  import adapter_pkg::*;

  // Link layer may send once link up is reached
  assign pl_trdy = link_up;

  link_bringup_fsm u_bringup (
    .com_clk           (com_clk),
    .rst_n             (rst_n),
    .i_conf_done       (i_conf_done),
    .ms_tx_transfer_en (ms_tx_transfer_en),
    .ms_rx_transfer_en (ms_rx_transfer_en),
    .sl_tx_transfer_en (sl_tx_transfer_en),
    .sl_rx_transfer_en (sl_rx_transfer_en),
    .align_done        (align_done),
    .ns_mac_rdy        (ns_mac_rdy),
    .ns_adapter_rstn   (ns_adapter_rstn),
    .tx_online         (tx_online),
    .rx_online         (rx_online),
    .link_up           (link_up)
  );

  // Raw codes pass in unchanged, illegal ones included
  dstrm_path u_dstrm (
    .com_clk      (com_clk),
    .rst_n        (rst_n),
    .link_up      (link_up),
    .lp_irdy      (lp_irdy),
    .lp_data      (lp_data),
    .lp_stream    (stream_id_e'(lp_stream)),
    .dstrm_data   (dstrm_data),
    .dstrm_protid (dstrm_protid),
    .dstrm_valid  (dstrm_valid)
  );

  ustrm_path u_ustrm (
    .com_clk      (com_clk),
    .rst_n        (rst_n),
    .ustrm_valid  (ustrm_valid),
    .ustrm_data   (ustrm_data),
    .ustrm_protid (protid_e'(ustrm_protid)),
    .pl_data      (pl_data),
    .pl_valid     (pl_valid),
    .pl_stream    (pl_stream)
  );

endmodule

// File: verif/tb_clk_gen.sv
// Testbench clock and reset generator
// 20 ns clock, active low reset held for three cycles
`timescale 1ns/1ps

module tb_clk_gen (
  output logic com_clk,
  output logic rst_n
);

  localparam int period_ns    = 20;
  localparam int reset_cycles = 3;

  initial begin
    com_clk = 1'b0;
    forever #(period_ns / 2) com_clk = ~com_clk;
  end

  initial begin
    rst_n <= 1'b0;
    repeat (reset_cycles) @(posedge com_clk);
    rst_n <= 1'b1;
  end

endmodule

// File: verif/tb_lpif_adapter.sv
// Testbench for the die-to-die link adapter control block
// Random bring-up order and traffic, checked against a cycle model
`timescale 1ns/1ps

module tb_lpif_adapter;

  import adapter_pkg::*;

  localparam int clk_period_ns  = 20;
  localparam int num_flits      = 48;
  localparam int timeout_cycles = 3 + 20 + 16 * 5 + 10 + num_flits + 32;

  logic                    com_clk, rst_n, i_conf_done, align_done;
  logic [4*aib_lanes-1:0]  xfer_en;
  logic                    ns_mac_rdy, tx_online, rx_online, link_up, pl_trdy;
  logic [aib_lanes-1:0]    ns_adapter_rstn;
  logic                    lp_irdy, dstrm_valid, ustrm_valid, pl_valid;
  logic [flit_width-1:0]   lp_data, dstrm_data, ustrm_data, pl_data;
  logic [2:0]              lp_stream, pl_stream;
  logic [1:0]              dstrm_protid, ustrm_protid;
  logic [15:0]             lfsr_state = 16'd45;

  // Cycle model state and expected outputs
  int                      model_stage;
  logic                    exp_dvalid, exp_pvalid;
  logic [flit_width-1:0]   exp_ddata, exp_pdata;
  logic [1:0]              exp_dprotid;
  logic [2:0]              exp_pstream;
  int                      valid_seen = 0;

  tb_clk_gen u_clk_gen (.com_clk(com_clk), .rst_n(rst_n));

  lpif_adapter_top u_dut (
    .com_clk (com_clk), .rst_n (rst_n), .i_conf_done (i_conf_done),
    .ms_tx_transfer_en (xfer_en[3:0]), .ms_rx_transfer_en (xfer_en[7:4]),
    .sl_tx_transfer_en (xfer_en[11:8]), .sl_rx_transfer_en (xfer_en[15:12]),
    .align_done (align_done), .ns_mac_rdy (ns_mac_rdy), .ns_adapter_rstn (ns_adapter_rstn),
    .tx_online (tx_online), .rx_online (rx_online), .link_up (link_up), .pl_trdy (pl_trdy),
    .lp_irdy (lp_irdy), .lp_data (lp_data), .lp_stream (lp_stream),
    .dstrm_data (dstrm_data), .dstrm_protid (dstrm_protid), .dstrm_valid (dstrm_valid),
    .ustrm_valid (ustrm_valid), .ustrm_data (ustrm_data), .ustrm_protid (ustrm_protid),
    .pl_data (pl_data), .pl_valid (pl_valid), .pl_stream (pl_stream)
  );

  //////////////////////
  // Random source
  //////////////////////

  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[62:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    rand_bits = r;
  endfunction

  //////////////////////
  // Reference model
  //////////////////////

  function automatic logic [1:0] stream_to_protid(logic [2:0] code);
    case (code)
      3'b010:  stream_to_protid = 2'd1;
      3'b100:  stream_to_protid = 2'd2;
      default: stream_to_protid = 2'd0;
    endcase
  endfunction

  function automatic logic [2:0] protid_to_stream(logic [1:0] code);
    case (code)
      2'd1:    protid_to_stream = 3'b010;
      2'd2:    protid_to_stream = 3'b100;
      default: protid_to_stream = 3'b001;
    endcase
  endfunction

  // Stages 0..5 follow idle, phy init, cfg, calib, align wait, link up
  function automatic int next_stage(int stage, logic conf, logic all_en, logic align);
    case (stage)
      0:       next_stage = 1;
      1:       next_stage = conf ? 2 : 1;
      2:       next_stage = 3;
      3:       next_stage = all_en ? 4 : 3;
      4:       next_stage = align ? 5 : 4;
      default: next_stage = 5;
    endcase
  endfunction

  // Packed as mac_rdy, adapter_rstn[3:0], tx_online, rx_online, link_up
  function automatic logic [7:0] expected_bringup(int stage);
    logic [7:0] o;
    o = '0;
    if (stage >= 2) o[7] = 1'b1;
    if (stage >= 3) o[6:3] = 4'hf;
    if (stage >= 4) o[2:1] = 2'b11;
    if (stage == 5) o[0] = 1'b1;
    expected_bringup = o;
  endfunction

  always @(posedge com_clk or negedge rst_n) begin
    if (!rst_n) begin
      model_stage = 0;
      {exp_dvalid, exp_pvalid, exp_ddata, exp_pdata, exp_dprotid, exp_pstream} = '0;
    end else begin
      // Valid is qualified by link up from before this edge
      exp_dvalid  = lp_irdy && (model_stage == 5);
      exp_ddata   = lp_data;
      exp_dprotid = stream_to_protid(lp_stream);
      exp_pvalid  = ustrm_valid;
      exp_pdata   = ustrm_data;
      exp_pstream = protid_to_stream(ustrm_protid);
      model_stage = next_stage(model_stage, i_conf_done, &xfer_en, align_done);
    end
  end

  //////////////////////
  // Checker
  //////////////////////

  task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
    assert (got === exp) else begin
      $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      $display("RESULT: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge com_clk) begin
    logic [7:0] seq;
    if (rst_n) begin
      seq = expected_bringup(model_stage);
      check_value("ns_mac_rdy", 64'(ns_mac_rdy), 64'(seq[7]));
      check_value("ns_adapter_rstn", 64'(ns_adapter_rstn), 64'(seq[6:3]));
      check_value("tx_online", 64'(tx_online), 64'(seq[2]));
      check_value("rx_online", 64'(rx_online), 64'(seq[1]));
      check_value("link_up", 64'(link_up), 64'(seq[0]));
      check_value("pl_trdy", 64'(pl_trdy), 64'(seq[0]));
      check_value("dstrm_valid", 64'(dstrm_valid), 64'(exp_dvalid));
      check_value("dstrm_data", dstrm_data, exp_ddata);
      check_value("dstrm_protid", 64'(dstrm_protid), 64'(exp_dprotid));
      check_value("pl_valid", 64'(pl_valid), 64'(exp_pvalid));
      check_value("pl_data", pl_data, exp_pdata);
      check_value("pl_stream", 64'(pl_stream), 64'(exp_pstream));
      if (dstrm_valid) valid_seen++;
    end
  end

  //////////////////////
  // Stimulus
  //////////////////////

  task automatic drive_random_traffic();
    logic [63:0] r;
    r = rand_bits(1);
    lp_irdy <= r[0];
    lp_data <= rand_bits(64);
    r = rand_bits(3);
    lp_stream <= r[2:0];
    r = rand_bits(1);
    ustrm_valid <= r[0];
    ustrm_data <= rand_bits(64);
    r = rand_bits(2);
    ustrm_protid <= r[1:0];
  endtask

  task automatic step_cycles(int n);
    repeat (n) begin
      @(posedge com_clk);
      drive_random_traffic();
    end
  endtask

  initial begin
    logic [63:0] r;
    int          idx;
    {i_conf_done, align_done, lp_irdy, ustrm_valid} <= '0;
    {xfer_en, lp_stream, ustrm_protid} <= '0;
    {lp_data, ustrm_data} <= '0;
    @(posedge rst_n);
    // Config done arrives after a random hold
    r = rand_bits(4);
    step_cycles(2 + int'(r[3:0]));
    @(posedge com_clk);
    i_conf_done <= 1'b1;
    drive_random_traffic();
    step_cycles(3);
    // Transfer enables one lane bit at a time, in random order
    for (int k = 0; k < 16; k++) begin
      r = rand_bits(4);
      idx = int'(r[3:0]);
      while (xfer_en[idx]) idx = (idx + 1) % 16;
      @(posedge com_clk);
      xfer_en[idx] <= 1'b1;
      drive_random_traffic();
      r = rand_bits(2);
      step_cycles(1 + int'(r[1:0]));
    end
    r = rand_bits(3);
    step_cycles(1 + int'(r[2:0]));
    @(posedge com_clk);
    align_done <= 1'b1;
    drive_random_traffic();
    while (!link_up) step_cycles(1);
    step_cycles(num_flits);
    @(posedge com_clk);
    lp_irdy <= 1'b0;
    ustrm_valid <= 1'b0;
    repeat (2) @(posedge com_clk);
    if (valid_seen > 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("Run ended without any downstream transfer");
      $display("RESULT: FAIL");
      $fatal(1, "no downstream traffic");
    end
  end

  // Watchdog
  initial begin
    #(timeout_cycles * clk_period_ns);
    $display("Timeout: bring-up or traffic did not finish in time");
    $display("RESULT: FAIL");
    $fatal(1, "timeout");
  end

endmodule

// File: lpif_adapter.f
src/adapter_pkg.sv
src/link_bringup_fsm.sv
src/dstrm_path.sv
src/ustrm_path.sv
src/lpif_adapter_top.sv
verif/tb_clk_gen.sv
verif/tb_lpif_adapter.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_lpif_adapter
FILELIST = lpif_adapter.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
